// File: booth_mul.f
mul_pkg.sv
booth_ctrl.sv
operand_prep.sv
booth_encoder.sv
booth_accum.sv
booth_mul.sv
tb_booth_mul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_booth_mul \
	-f booth_mul.f \
	&& ./obj_dir/Vtb_booth_mul | tee /dev/stderr | grep "Test passed" > /dev/null \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

// File: tb_booth_mul.sv
`timescale 1ns/10ps

module tb_booth_mul;
	import mul_pkg::*;

	// about 200 operations of mostly 36 cycles plus flush waits and reset
	// come to roughly 8300 cycles
	localparam int max_cycles = 10000;
	localparam int lat_d = 34;
	localparam int lat_w = 18;
	// accept to accept with mul_valid held high
	localparam int b2b_gap = 36;

	localparam logic [63:0] corners [8] = '{
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0001,
		64'hffff_ffff_ffff_ffff,
		64'h8000_0000_0000_0000,
		64'h7fff_ffff_ffff_ffff,
		64'haaaa_aaaa_aaaa_aaaa,
		64'h5555_5555_5555_5555,
		64'h0000_0000_ffff_ffff
	};

	logic        clk;
	logic        rst;
	logic        mul_valid;
	logic        flush;
	logic        mulw;
	mul_sign_t   mul_signed;
	logic [63:0] multiplicand;
	logic [63:0] multiplier;
	logic        mul_ready;
	logic        out_valid;
	logic [63:0] result_hi;
	logic [63:0] result_lo;

	int          cycle_cnt = 0;
	int unsigned seed_ret;

	booth_mul dut (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// run length guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("Error: time %0t, the run did not finish within %0d cycles", $time,
				max_cycles);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// **************************************************
	// helpers
	// **************************************************

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Error: time %0t, %s = 0x%h, expected 0x%h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error: time %0t, %s", $time, what);
			abort_run();
		end
	endtask

	function automatic logic [63:0] rand64();
		return {$urandom(), $urandom()};
	endfunction

	function automatic mul_sign_t rand_sign();
		logic [1:0] v;
		v = 2'($urandom_range(3, 0));
		return mul_sign_t'(v);
	endfunction

	// 128-bit product from operands extended per the sign code
	// two's complement wraps modulo 2^128, so a plain multiply is enough
	function automatic logic [127:0] ref_product(input logic w, input logic [1:0] s,
		input logic [63:0] a, input logic [63:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		logic [31:0]  lo32;
		if (w) begin
			// word ops always sign-extend the low words
			ea = {{96{a[31]}}, a[31:0]};
			eb = {{96{b[31]}}, b[31:0]};
			p = ea * eb;
			lo32 = p[31:0];
			return {{96{lo32[31]}}, lo32};
		end
		ea = {{64{s[1] & a[63]}}, a};
		eb = {{64{s[0] & b[63]}}, b};
		p = ea * eb;
		return p;
	endfunction

	// one request, wait for out_valid, check latency and product
	task automatic do_mul(input logic w, input mul_sign_t s, input logic [63:0] a,
		input logic [63:0] b);
		logic [127:0] exp;
		int           lat;
		int           cycles;
		exp = ref_product(w, s, a, b);
		lat = w ? lat_w : lat_d;
		check_value("mul_ready", 64'(mul_ready), 64'd1);
		mul_valid = 1'b1;
		mulw = w;
		mul_signed = s;
		multiplicand = a;
		multiplier = b;
		@(posedge clk);
		#1;
		// accepted on that edge so the inputs no longer matter
		mul_valid = 1'b0;
		mulw = ~w;
		mul_signed = rand_sign();
		multiplicand = rand64();
		multiplier = rand64();
		cycles = 0;
		while (out_valid !== 1'b1) begin
			check_value("mul_ready", 64'(mul_ready), 64'd0);
			@(posedge clk);
			#1;
			cycles++;
			check_true(cycles <= lat, "out_valid did not rise within the expected latency");
		end
		check_value("latency", 64'(cycles), 64'(lat));
		check_value("mul_ready", 64'(mul_ready), 64'd0);
		check_value("result_hi", result_hi, exp[127:64]);
		check_value("result_lo", result_lo, exp[63:0]);
		@(posedge clk);
		#1;
		// single-cycle pulse with ready right after
		check_value("out_valid", 64'(out_valid), 64'd0);
		check_value("mul_ready", 64'(mul_ready), 64'd1);
		check_value("result_hi", result_hi, exp[127:64]);
		check_value("result_lo", result_lo, exp[63:0]);
	endtask

	// **************************************************
	// directed tests
	// **************************************************

	task automatic test_reset();
		check_value("mul_ready", 64'(mul_ready), 64'd1);
		check_value("out_valid", 64'(out_valid), 64'd0);
		check_value("result_hi", result_hi, 64'd0);
		check_value("result_lo", result_lo, 64'd0);
	endtask

	task automatic test_signed();
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				do_mul(1'b0, sign_ss, corners[i], corners[j]);
			end
		end
		repeat (60) do_mul(1'b0, sign_ss, rand64(), rand64());
	endtask

	task automatic test_sign_modes();
		mul_sign_t   modes [3];
		logic [63:0] a;
		logic [63:0] b;
		modes = '{sign_uu, sign_su, sign_us};
		foreach (modes[m]) begin
			for (int i = 0; i < 8; i++) begin
				do_mul(1'b0, modes[m], corners[i], corners[(i + 3) % 8]);
			end
			for (int k = 0; k < 12; k++) begin
				a = rand64();
				b = rand64();
				// top bit set on alternate pairs
				if (k % 2 == 1) begin
					a[63] = 1'b1;
					b[63] = 1'b1;
				end
				do_mul(1'b0, modes[m], a, b);
			end
		end
	endtask

	task automatic test_word_mode();
		logic [63:0] a;
		logic [63:0] b;
		for (int k = 0; k < 12; k++) begin
			a = (k < 8) ? corners[k] : rand64();
			b = (k < 8) ? corners[7 - k] : rand64();
			do_mul(1'b1, rand_sign(), a, b);
			// same low words with other upper halves and sign code
			a[63:32] = $urandom();
			b[63:32] = $urandom();
			do_mul(1'b1, rand_sign(), a, b);
		end
	endtask

	// flush a doubleword op some cycles after accept
	task automatic flush_mid_op(input int delay);
		logic [63:0] prev_hi;
		logic [63:0] prev_lo;
		prev_hi = result_hi;
		prev_lo = result_lo;
		mul_valid = 1'b1;
		mulw = 1'b0;
		mul_signed = rand_sign();
		multiplicand = rand64();
		multiplier = rand64();
		@(posedge clk);
		#1;
		mul_valid = 1'b0;
		repeat (delay - 1) begin
			check_value("out_valid", 64'(out_valid), 64'd0);
			@(posedge clk);
			#1;
		end
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		check_value("mul_ready", 64'(mul_ready), 64'd1);
		// no late pulse and the old result untouched
		repeat (40) begin
			check_value("out_valid", 64'(out_valid), 64'd0);
			check_value("result_hi", result_hi, prev_hi);
			check_value("result_lo", result_lo, prev_lo);
			@(posedge clk);
			#1;
		end
	endtask

	task automatic test_flush();
		repeat (10) begin
			flush_mid_op($urandom_range(30, 1));
			do_mul(1'b0, sign_ss, rand64(), rand64());
		end
	endtask

	// mul_valid held high with operands scrambled while busy
	task automatic test_back_to_back(input int n_ops);
		logic [127:0] exp_q [$];
		logic [127:0] exp;
		logic [63:0]  a;
		logic [63:0]  b;
		mul_sign_t    s;
		int           accepted;
		int           done_cnt;
		int           gap;
		accepted = 0;
		done_cnt = 0;
		gap = 0;
		while (done_cnt < n_ops) begin
			if (out_valid) begin
				check_true(exp_q.size() > 0, "out_valid pulsed with no accepted request");
				exp = exp_q.pop_front();
				check_value("result_hi", result_hi, exp[127:64]);
				check_value("result_lo", result_lo, exp[63:0]);
				if (done_cnt > 0) begin
					check_value("out_valid spacing", 64'(gap), 64'(b2b_gap));
				end
				done_cnt++;
				gap = 0;
			end
			if (mul_ready) begin
				if (accepted < n_ops) begin
					a = rand64();
					b = rand64();
					s = rand_sign();
					mul_valid = 1'b1;
					mulw = 1'b0;
					mul_signed = s;
					multiplicand = a;
					multiplier = b;
					exp_q.push_back(ref_product(1'b0, s, a, b));
					accepted++;
				end else begin
					mul_valid = 1'b0;
				end
			end else begin
				// must be ignored
				mul_valid = 1'b1;
				mulw = 1'($urandom_range(1, 0));
				mul_signed = rand_sign();
				multiplicand = rand64();
				multiplier = rand64();
			end
			@(posedge clk);
			#1;
			gap++;
		end
		mul_valid = 1'b0;
		mulw = 1'b0;
		@(posedge clk);
		#1;
		check_value("mul_ready", 64'(mul_ready), 64'd1);
		check_true(exp_q.size() == 0, "an accepted request never completed");
	endtask

	// **************************************************
	// main sequence
	// **************************************************

	initial begin
		seed_ret = $urandom(32'hd904_f3a0);
		clk = 1'b0;
		rst = 1'b1;
		mul_valid = 1'b0;
		flush = 1'b0;
		mulw = 1'b0;
		mul_signed = sign_ss;
		multiplicand = '0;
		multiplier = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		test_reset();
		test_signed();
		test_sign_modes();
		test_word_mode();
		test_flush();
		test_back_to_back(4);

		$display("Test passed");
		$finish;
	end

endmodule

// File: booth_mul.sv
`timescale 1ns/10ps

module booth_mul (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     mul_valid,
	input  logic                     flush,
	input  logic                     mulw,
	input  mul_pkg::mul_sign_t       mul_signed,
	input  logic [mul_pkg::xlen-1:0] multiplicand,
	input  logic [mul_pkg::xlen-1:0] multiplier,
	output logic                     mul_ready,
	output logic                     out_valid,
	output logic [mul_pkg::xlen-1:0] result_hi,
	output logic [mul_pkg::xlen-1:0] result_lo
);
	import mul_pkg::*;

	// control strobes
	logic             load;
	logic             step;
	logic             finish;
	logic             word_q;
	// extended operands, combinational from the inputs
	logic [ext_w-1:0] ext_cand;
	logic [ext_w-1:0] ext_plier;
	// booth digit path
	logic [2:0]       window;
	logic [acc_w-1:0] cand_sh;
	logic [acc_w-1:0] part_prod;

	// **************************************************
	// control
	// **************************************************

	booth_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mulw      (mulw),
		.mul_ready (mul_ready),
		.out_valid (out_valid),
		.load      (load),
		.step      (step),
		.finish    (finish),
		.word_q    (word_q)
	);

	// **************************************************
	// datapath
	// **************************************************

	// operands are only sampled on the load edge
	operand_prep u_prep (
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.ext_cand     (ext_cand),
		.ext_plier    (ext_plier)
	);

	booth_accum u_accum (
		.clk       (clk),
		.rst       (rst),
		.load      (load),
		.step      (step),
		.finish    (finish),
		.word_q    (word_q),
		.ext_cand  (ext_cand),
		.ext_plier (ext_plier),
		.part_prod (part_prod),
		.window    (window),
		.cand_sh   (cand_sh),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

	// one partial product per cycle
	booth_encoder u_enc (
		.window    (window),
		.cand_sh   (cand_sh),
		.part_prod (part_prod)
	);

endmodule

// File: booth_accum.sv
`timescale 1ns/10ps

module booth_accum (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      load,
	input  logic                      step,
	input  logic                      finish,
	input  logic                      word_q,
	input  logic [mul_pkg::ext_w-1:0] ext_cand,
	input  logic [mul_pkg::ext_w-1:0] ext_plier,
	input  logic [mul_pkg::acc_w-1:0] part_prod,
	output logic [2:0]                window,
	output logic [mul_pkg::acc_w-1:0] cand_sh,
	output logic [mul_pkg::xlen-1:0]  result_hi,
	output logic [mul_pkg::xlen-1:0]  result_lo
);
	import mul_pkg::*;

	// multiplier with the implicit zero below the lsb
	logic [ext_w:0]   plier_q;
	// running sum of partial products
	logic [acc_w-1:0] acc;
	// sum including the current digit
	logic [acc_w-1:0] sum;
	logic [xlen-1:0]  fmt_hi;
	logic [xlen-1:0]  fmt_lo;

	// **************************************************
	// shift registers and accumulator
	// **************************************************

	// lowest three bits select the current booth digit
	assign window = plier_q[2:0];

	assign sum = acc + part_prod;

	always_ff @(posedge clk) begin
		if (load) begin
			// sign-extend to the accumulator width
			cand_sh <= {{(acc_w-ext_w){ext_cand[ext_w-1]}}, ext_cand};
			plier_q <= {ext_plier, 1'b0};
			acc     <= '0;
		end else if (step) begin
			// next digit weighs four times more
			cand_sh <= {cand_sh[acc_w-3:0], 2'b00};
			// arithmetic shift, top windows decode to zero
			plier_q <= {{2{plier_q[ext_w]}}, plier_q[ext_w:2]};
			acc     <= sum;
		end
	end

	// **************************************************
	// result formatting
	// **************************************************

	always_comb begin
		if (word_q) begin
			// mulw: sign-extended low word, high half all copies of bit 31
			fmt_lo = {{(xlen-32){sum[31]}}, sum[31:0]};
			fmt_hi = {xlen{sum[31]}};
		end else begin
			// full 128-bit product split in halves
			fmt_lo = sum[xlen-1:0];
			fmt_hi = sum[2*xlen-1:xlen];
		end
	end

	// result registers
	// hold their value until the next completed operation
	always_ff @(posedge clk) begin
		if (rst) begin
			result_hi <= '0;
			result_lo <= '0;
		end else if (finish) begin
			result_hi <= fmt_hi;
			result_lo <= fmt_lo;
		end
	end

endmodule

// File: booth_encoder.sv
`timescale 1ns/10ps

module booth_encoder (
	input  logic [2:0]                window,
	input  logic [mul_pkg::acc_w-1:0] cand_sh,
	output logic [mul_pkg::acc_w-1:0] part_prod
);
	import mul_pkg::*;

	logic [acc_w-1:0] mag;
	logic             neg;

	// **************************************************
	// radix-4 recoding
	// **************************************************

	// window is {b(2i+1), b(2i), b(2i-1)}
	// digit = -2*b(2i+1) + b(2i) + b(2i-1)
	always_comb begin
		mag = '0;
		neg = 1'b0;
		case (window)
			3'b000, 3'b111: begin
				// digit 0
				mag = '0;
				neg = 1'b0;
			end
			3'b001, 3'b010: begin
				// +X
				mag = cand_sh;
				neg = 1'b0;
			end
			3'b011: begin
				// +2X
				mag = {cand_sh[acc_w-2:0], 1'b0};
				neg = 1'b0;
			end
			3'b100: begin
				// -2X
				mag = {cand_sh[acc_w-2:0], 1'b0};
				neg = 1'b1;
			end
			3'b101, 3'b110: begin
				// -X
				mag = cand_sh;
				neg = 1'b1;
			end
			default: begin
				mag = '0;
				neg = 1'b0;
			end
		endcase
	end

	// full-width two's complement
	// so no +1 correction is carried into the accumulator
	assign part_prod = neg ? (~mag + acc_w'(1)) : mag;

endmodule

// File: operand_prep.sv
`timescale 1ns/10ps

module operand_prep (
	input  logic                      mulw,
	input  mul_pkg::mul_sign_t        mul_signed,
	input  logic [mul_pkg::xlen-1:0]  multiplicand,
	input  logic [mul_pkg::xlen-1:0]  multiplier,
	output logic [mul_pkg::ext_w-1:0] ext_cand,
	output logic [mul_pkg::ext_w-1:0] ext_plier
);
	import mul_pkg::*;

	logic cand_sgn;
	logic plier_sgn;
	logic cand_top;
	logic plier_top;

	// **************************************************
	// sign decode
	// **************************************************

	// multiplicand signed for su and ss
	assign cand_sgn = (mul_signed == sign_su) || (mul_signed == sign_ss);
	// multiplier signed for us and ss
	assign plier_sgn = (mul_signed == sign_us) || (mul_signed == sign_ss);

	// fill bit for doubleword mode, zero when unsigned
	assign cand_top = cand_sgn && multiplicand[xlen-1];
	assign plier_top = plier_sgn && multiplier[xlen-1];

	// **************************************************
	// extension
	// **************************************************

	always_comb begin
		if (mulw) begin
			// word ops always sign-extend the low word
			// upper 32 bits and sign mode are ignored here
			ext_cand  = {{(ext_w-32){multiplicand[31]}}, multiplicand[31:0]};
			ext_plier = {{(ext_w-32){multiplier[31]}}, multiplier[31:0]};
		end else begin
			// two extra bits so an unsigned 64-bit value stays positive
			ext_cand  = {{(ext_w-xlen){cand_top}}, multiplicand};
			ext_plier = {{(ext_w-xlen){plier_top}}, multiplier};
		end
	end

endmodule

// File: booth_ctrl.sv
`timescale 1ns/10ps

module booth_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic mul_valid,
	input  logic flush,
	input  logic mulw,
	output logic mul_ready,
	output logic out_valid,
	output logic load,
	output logic step,
	output logic finish,
	output logic word_q
);
	import mul_pkg::*;

	mul_state_t       state;
	mul_state_t       state_nx;
	logic [cnt_w-1:0] cnt;
	logic             last_iter;

	// **************************************************
	// handshake and datapath strobes
	// **************************************************

	// only idle takes a new request
	assign mul_ready = (state == st_idle);
	// flush wins over accept
	assign load = mul_ready && mul_valid && !flush;
	// every busy cycle retires one booth digit
	assign step = (state == st_busy);
	assign last_iter = (cnt == cnt_w'(1));
	// a flushed last iteration must not touch the result registers
	assign finish = step && last_iter && !flush;

	// next state
	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				if (load) begin
					state_nx = st_busy;
				end
			end
			st_busy: begin
				if (flush) begin
					state_nx = st_idle;
				end else if (last_iter) begin
					state_nx = st_done;
				end
			end
			st_done: begin
				// stay until the out_valid cycle has been seen
				if (flush || out_valid) begin
					state_nx = st_idle;
				end
			end
			default: begin
				state_nx = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nx;
		end
	end

	// iteration counter, loaded on accept
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			word_q <= 1'b0;
		end else if (load) begin
			cnt    <= mulw ? cnt_w'(iter_w) : cnt_w'(iter_d);
			// word mode held for result formatting
			word_q <= mulw;
		end else if (step) begin
			cnt <= cnt - cnt_w'(1);
		end
	end

	// done pulse, one cycle after entering st_done
	// not raised again while it is already high
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= (state == st_done) && !out_valid && !flush;
		end
	end

endmodule

// File: mul_pkg.sv
package mul_pkg;

	// **************************************************
	// datapath widths
	// **************************************************

	// architectural operand width
	localparam int xlen = 64;
	// operand plus two sign bits, even so radix-4 digits tile it exactly
	localparam int ext_w = 66;
	// full signed product of two extended operands
	localparam int acc_w = 132;

	// **************************************************
	// iteration control
	// **************************************************

	// one radix-4 digit per iteration, 66 / 2
	localparam int iter_d = 33;
	// word mode only needs the low 34 bits of the multiplier
	localparam int iter_w = 17;
	// counter wide enough for iter_d
	localparam int cnt_w = 6;

	// control FSM states
	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_done
	} mul_state_t;

	// per-operand signedness, bit 1 multiplicand, bit 0 multiplier
	// mul -> sign_ss, mulh -> sign_ss, mulhsu -> sign_su, mulhu -> sign_uu
	typedef enum logic [1:0] {
		sign_uu = 2'd0,
		sign_us = 2'd1,
		sign_su = 2'd2,
		sign_ss = 2'd3
	} mul_sign_t;

endpackage
